// ==== icache_top.f ====
+incdir+common
common/ic_pkg.sv
common/ic_store_if.sv
icache/ic_store.sv
icache/ic_fetch_align.sv
icache/ic_ctrl.sv
icache/icache_top.sv
dv/icache_props.sv
dv/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f icache_top.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation reported failures"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== dv/icache_tb.sv ====
// ############################
// Instruction cache testbench
// Memory model, row table, checks
// ############################

`timescale 1ns/100ps

`include "ic_params.svh"

module icache_tb
    import ic_pkg::*;
();

    localparam logic [31:0] SEED = 32'h1455_fbe5;

    logic clk_i, rst_ni, flush_i, fe_valid_i, ic_ready_o, dec_ready_i;
    pc_t fe_pc_i, ic_pc_o;
    fetch_mask_t fe_fetch_mask_i, ic_valid_o, ic_fetch_mask_o;
    act_mask_t fe_act_mask_i, ic_act_mask_o;
    wid_t fe_warp_id_i, ic_warp_id_o;
    inst_t [`IC_FETCH_WIDTH-1:0] ic_inst_o;
    logic mem_req_o, mem_ready_i, mem_valid_i;
    line_addr_t mem_addr_o;
    line_t mem_data_i;

    // Row table
    pc_t         row_pc[$];
    fetch_mask_t row_mask[$];
    wid_t        row_wid[$];
    act_mask_t   row_act[$];
    logic        row_flush[$];

    // Reference tags and valids
    tag_t model_tag   [`IC_NUM_LINES];
    logic model_valid [`IC_NUM_LINES];

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycle_limit = 100000;
    int mem_reqs = 0;
    line_addr_t last_req_addr;

    icache_top DUT (.*);

    bind icache_top icache_props u_props (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the cache stopped responding", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Word k of line a
    function automatic inst_t mem_word(input line_addr_t a, input int k);
        int v;
        v = int'(a) * 3 + k;
        return inst_t'(v % 16);
    endfunction

    function automatic line_t mem_line(input line_addr_t a);
        line_t l;
        for (int k = 0; k < `IC_LINE_INSTS; k++) begin
            l[k] = mem_word(a, k);
        end
        return l;
    endfunction

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input pc_t pc, input fetch_mask_t mask, input wid_t wid,
                           input act_mask_t act, input logic flush);
        row_pc.push_back(pc);
        row_mask.push_back(mask);
        row_wid.push_back(wid);
        row_act.push_back(act);
        row_flush.push_back(flush);
    endtask

    // ############################
    // Memory model
    // ############################

    initial begin : memory_model
        int lat;
        mem_ready_i = 1'b1;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        forever begin
            @(negedge clk_i);
            if (rst_ni && mem_req_o && mem_ready_i) begin
                mem_reqs++;
                last_req_addr = mem_addr_o;
                lat = 1 + int'($urandom % 4);
                @(posedge clk_i);
                #1;
                mem_ready_i = 1'b0;
                repeat (lat - 1) begin
                    @(posedge clk_i);
                    #1;
                end
                mem_valid_i = 1'b1;
                mem_data_i  = mem_line(last_req_addr);
                @(posedge clk_i);
                #1;
                mem_valid_i = 1'b0;
                mem_data_i  = '0;
                mem_ready_i = 1'b1;
            end
        end
    end

    // ############################
    // One row, starting 1 ns after an edge
    // ############################

    task automatic run_row(input int r);
        pc_t pc;
        fetch_mask_t mask, exp_valid, hold_valid, hold_fmask;
        line_addr_t la;
        offset_t off;
        index_t idx;
        tag_t tag;
        logic exp_hit;
        int reqs_before, stall;
        inst_t [`IC_FETCH_WIDTH-1:0] exp_inst, hold_inst;
        pc_t hold_pc;
        act_mask_t hold_act;
        wid_t hold_wid;
        pc   = row_pc[r];
        mask = row_mask[r];
        la   = pc[`IC_PC_WIDTH-1:`IC_LINE_IDX_BITS];
        off  = pc[`IC_LINE_IDX_BITS-1:0];
        idx  = la[$bits(index_t)-1:0];
        tag  = la[$bits(line_addr_t)-1 -: $bits(tag_t)];

        if (row_flush[r]) begin
            flush_i = 1'b1;
            @(posedge clk_i);
            #1;
            flush_i = 1'b0;
            for (int i = 0; i < `IC_NUM_LINES; i++) begin
                model_valid[i] = 1'b0;
            end
        end

        exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
        exp_valid = '0;
        exp_inst  = '0;
        for (int k = 0; k < `IC_FETCH_WIDTH; k++) begin
            if (mask[k] && (int'(off) + k) < `IC_LINE_INSTS) begin
                exp_valid[k] = 1'b1;
                exp_inst[k]  = mem_word(la, int'(off) + k);
            end
        end

        reqs_before     = mem_reqs;
        fe_valid_i      = 1'b1;
        fe_pc_i         = pc;
        fe_fetch_mask_i = mask;
        fe_act_mask_i   = row_act[r];
        fe_warp_id_i    = row_wid[r];
        @(negedge clk_i);
        while (!ic_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        fe_valid_i = 1'b0;

        @(negedge clk_i);
        while (ic_valid_o == '0) begin
            @(negedge clk_i);
        end
        check_eq("memory requests", 64'(mem_reqs - reqs_before), exp_hit ? 64'd0 : 64'd1);
        if (!exp_hit) begin
            check_eq("memory address", 64'(last_req_addr), 64'(la));
        end
        check_eq("slot valid", 64'(ic_valid_o), 64'(exp_valid));
        check_eq("instructions", 64'(ic_inst_o), 64'(exp_inst));
        check_eq("pc", 64'(ic_pc_o), 64'(pc));
        check_eq("fetch mask", 64'(ic_fetch_mask_o), 64'(mask));
        check_eq("active mask", 64'(ic_act_mask_o), 64'(row_act[r]));
        check_eq("warp id", 64'(ic_warp_id_o), 64'(row_wid[r]));

        hold_valid = ic_valid_o;
        hold_inst  = ic_inst_o;
        hold_pc    = ic_pc_o;
        hold_fmask = ic_fetch_mask_o;
        hold_act   = ic_act_mask_o;
        hold_wid   = ic_warp_id_o;
        stall = int'($urandom % 4);
        repeat (stall) begin
            @(negedge clk_i);
            checks++;
            if (ic_valid_o !== hold_valid || ic_inst_o !== hold_inst || ic_pc_o !== hold_pc
                    || ic_fetch_mask_o !== hold_fmask || ic_act_mask_o !== hold_act
                    || ic_warp_id_o !== hold_wid) begin
                errors++;
                $display("FAIL at %0t: outputs moved under a decoder stall, row %0d", $time, r);
            end
        end

        // Consume at the next edge
        @(posedge clk_i);
        #1;
        dec_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        dec_ready_i = 1'b0;
    endtask

    // ############################
    // Main sequence
    // ############################

    initial begin : main
        int prop_fails;
        void'($urandom(SEED));
        rst_ni = 1'b0;
        flush_i = 1'b0;
        fe_valid_i = 1'b0;
        fe_pc_i = '0;
        fe_fetch_mask_i = '0;
        fe_act_mask_i = '0;
        fe_warp_id_i = '0;
        dec_ready_i = 1'b0;
        for (int i = 0; i < `IC_NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end

        // pc, fetch mask, warp, active mask, flush first
        add_row(8'h00, 4'b1111, 3'd0, 32'hffff_ffff, 1'b0);
        add_row(8'h01, 4'b0011, 3'd1, 32'h0000_00ff, 1'b0);
        add_row(8'h02, 4'b1111, 3'd2, 32'h1234_5678, 1'b0);
        add_row(8'h03, 4'b0111, 3'd3, 32'h8000_0001, 1'b0);
        add_row(8'h24, 4'b1111, 3'd4, 32'hdead_beef, 1'b0);
        add_row(8'h25, 4'b0001, 3'd5, 32'h0f0f_0f0f, 1'b0);
        add_row(8'h20, 4'b0111, 3'd6, 32'hffff_0000, 1'b0);
        add_row(8'h00, 4'b1111, 3'd7, 32'h0000_ffff, 1'b0);
        add_row(8'h26, 4'b0011, 3'd0, 32'h5555_aaaa, 1'b0);
        add_row(8'he7, 4'b1111, 3'd1, 32'h0000_0001, 1'b0);
        add_row(8'h03, 4'b0001, 3'd2, 32'hcafe_f00d, 1'b1);
        add_row(8'h1c, 4'b1111, 3'd3, 32'h7777_7777, 1'b0);
        add_row(8'h1d, 4'b0011, 3'd4, 32'h0101_0101, 1'b0);
        add_row(8'h1c, 4'b0111, 3'd5, 32'hffff_fffe, 1'b1);
        add_row(8'hff, 4'b1111, 3'd6, 32'h3c3c_3c3c, 1'b0);
        add_row(8'hfe, 4'b0011, 3'd7, 32'h8888_0000, 1'b0);
        cycle_limit = row_pc.size() * 20 + 100;

        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_eq("ready after reset", 64'(ic_ready_o), 64'd1);
        check_eq("valid after reset", 64'(ic_valid_o), 64'd0);
        check_eq("request after reset", 64'(mem_req_o), 64'd0);
        @(posedge clk_i);
        #1;

        for (int r = 0; r < row_pc.size(); r++) begin
            run_row(r);
        end
        repeat (2) @(posedge clk_i);

        prop_fails = DUT.u_props.fail_count;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/icache_props.sv ====
// ############################
// Port assertions for the instruction cache
// ############################

`timescale 1ns/100ps

`include "ic_params.svh"

module icache_props
    import ic_pkg::*;
(
    input logic                        clk_i,
    input logic                        rst_ni,
    input logic                        fe_valid_i,
    input fetch_mask_t                 fe_fetch_mask_i,
    input fetch_mask_t                 ic_valid_o,
    input inst_t [`IC_FETCH_WIDTH-1:0] ic_inst_o,
    input pc_t                         ic_pc_o,
    input fetch_mask_t                 ic_fetch_mask_o,
    input act_mask_t                   ic_act_mask_o,
    input wid_t                        ic_warp_id_o,
    input logic                        dec_ready_i,
    input logic                        mem_req_o,
    input logic                        mem_ready_i,
    input logic                        mem_valid_i
);

    int   contig_fails = 0;
    int   stable_fails = 0;
    int   mem_fails    = 0;
    int   fetch_fails  = 0;
    int   fail_count;
    logic mem_pending;

    assign fail_count = contig_fails + stable_fails + mem_fails + fetch_fails;

    // Line request taken by memory and not yet answered
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_pending <= 1'b0;
        end else if (mem_req_o && mem_ready_i) begin
            mem_pending <= 1'b1;
        end else if (mem_valid_i) begin
            mem_pending <= 1'b0;
        end
    end

    // Valid slots form a run starting at slot 0
    valid_contiguous: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((ic_valid_o + fetch_mask_t'(1)) & ic_valid_o) == '0)
    else begin
        $error("ic_valid_o is not contiguous: %b", ic_valid_o);
        contig_fails++;
    end

    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ic_valid_o != '0 && !dec_ready_i) |=>
            ($stable(ic_valid_o) && $stable(ic_inst_o) && $stable(ic_pc_o)
             && $stable(ic_fetch_mask_o) && $stable(ic_act_mask_o)
             && $stable(ic_warp_id_o)))
    else begin
        $error("decoder outputs changed during a stall");
        stable_fails++;
    end

    resp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_valid_i |-> mem_pending)
    else begin
        $error("mem_valid_i without an outstanding line request");
        mem_fails++;
    end

    fetch_mask_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fe_valid_i |-> (fe_fetch_mask_i != '0 && fe_fetch_mask_i[0]))
    else begin
        $error("fetch mask %b has slot 0 clear", fe_fetch_mask_i);
        fetch_fails++;
    end

endmodule

// ==== icache/icache_top.sv ====
// ############################
// Direct-mapped instruction cache
// Fetcher, decoder and line refill ports
// ############################

`timescale 1ns/100ps

`include "ic_params.svh"

module icache_top
    import ic_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        flush_i,

    // Fetcher
    input  logic                        fe_valid_i,
    input  pc_t                         fe_pc_i,
    input  fetch_mask_t                 fe_fetch_mask_i,
    input  act_mask_t                   fe_act_mask_i,
    input  wid_t                        fe_warp_id_i,
    output logic                        ic_ready_o,

    // Decoder
    output fetch_mask_t                 ic_valid_o,
    output inst_t [`IC_FETCH_WIDTH-1:0] ic_inst_o,
    output pc_t                         ic_pc_o,
    output fetch_mask_t                 ic_fetch_mask_o,
    output act_mask_t                   ic_act_mask_o,
    output wid_t                        ic_warp_id_o,
    input  logic                        dec_ready_i,

    // Memory
    output logic                        mem_req_o,
    output line_addr_t                  mem_addr_o,
    input  logic                        mem_ready_i,
    input  logic                        mem_valid_i,
    input  line_t                       mem_data_i
);

    fetch_req_t fe_req;
    fetch_req_t held_req;
    logic       out_valid;
    logic       use_refill;
    line_t      store_line;

    ic_store_if store_if ();

    // Pack the fetcher sideband
    assign fe_req = '{
        pc:         fe_pc_i,
        fetch_mask: fe_fetch_mask_i,
        act_mask:   fe_act_mask_i,
        warp_id:    fe_warp_id_i
    };

    ic_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .fe_valid_i   (fe_valid_i),
        .fe_req_i     (fe_req),
        .ic_ready_o   (ic_ready_o),
        .dec_ready_i  (dec_ready_i),
        .out_valid_o  (out_valid),
        .req_o        (held_req),
        .use_refill_o (use_refill),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_ready_i  (mem_ready_i),
        .mem_valid_i  (mem_valid_i),
        .mem_data_i   (mem_data_i),
        .store        (store_if.ctrl)
    );

    ic_store u_store (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .port   (store_if.store),
        .line_o (store_line)
    );

    ic_fetch_align u_align (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .out_valid_i     (out_valid),
        .use_refill_i    (use_refill),
        .req_i           (held_req),
        .store_line_i    (store_line),
        .mem_valid_i     (mem_valid_i),
        .mem_data_i      (mem_data_i),
        .ic_valid_o      (ic_valid_o),
        .ic_inst_o       (ic_inst_o),
        .ic_pc_o         (ic_pc_o),
        .ic_fetch_mask_o (ic_fetch_mask_o),
        .ic_act_mask_o   (ic_act_mask_o),
        .ic_warp_id_o    (ic_warp_id_o)
    );

endmodule

// ==== icache/ic_ctrl.sv ====
// ############################
// Instruction cache controller
// Request FSM, held request and pending flush
// ############################

`timescale 1ns/100ps

module ic_ctrl
    import ic_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       flush_i,

    // Fetcher side
    input  logic       fe_valid_i,
    input  fetch_req_t fe_req_i,
    output logic       ic_ready_o,

    // Decoder side
    input  logic       dec_ready_i,
    output logic       out_valid_o,
    output fetch_req_t req_o,
    output logic       use_refill_o,

    // Memory side
    output logic       mem_req_o,
    output line_addr_t mem_addr_o,
    input  logic       mem_ready_i,
    input  logic       mem_valid_i,
    input  line_t      mem_data_i,

    ic_store_if.ctrl   store
);

    ic_state_e  state_q;
    ic_state_e  state_d;
    fetch_req_t req_q;
    logic       flush_q;

    logic       accept;
    logic       consume;
    logic       flush_take;

    // ############################
    // Handshakes
    // ############################

    // Hit result is only meaningful in LOOKUP
    assign out_valid_o  = ((state_q == LOOKUP) && store.hit) || (state_q == WAIT_DEC);
    assign use_refill_o = (state_q == WAIT_DEC);

    assign consume = out_valid_o && dec_ready_i;

    // Pending flush wins over a new fetch
    assign flush_take = flush_q && ((state_q == IDLE) || consume);
    assign ic_ready_o = ((state_q == IDLE) || consume) && !flush_q;
    assign accept     = fe_valid_i && ic_ready_o;

    // Line request stays up until memory takes it
    assign mem_req_o  = (state_q == LOOKUP) && !store.hit;
    assign mem_addr_o = req_q.pc[$bits(pc_t)-1:$bits(offset_t)];

    assign req_o = req_q;

    // ############################
    // Store control
    // ############################

    // Lookup straight from the fetcher, result comes back next cycle
    assign store.lookup     = accept;
    assign store.lookup_idx = fe_req_i.pc[$bits(offset_t) +: $bits(index_t)];
    assign store.lookup_tag = fe_req_i.pc[$bits(pc_t)-1 -: $bits(tag_t)];

    assign store.fill      = (state_q == WAIT_MEM) && mem_valid_i;
    assign store.fill_idx  = req_q.pc[$bits(offset_t) +: $bits(index_t)];
    assign store.fill_tag  = req_q.pc[$bits(pc_t)-1 -: $bits(tag_t)];
    assign store.fill_data = mem_data_i;

    assign store.clear = flush_take;

    // ############################
    // FSM
    // ############################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (store.hit) begin
                    if (dec_ready_i) begin
                        state_d = accept ? LOOKUP : IDLE;
                    end
                end else if (mem_ready_i) begin
                    state_d = WAIT_MEM;
                end
            end
            WAIT_MEM: begin
                // Single strobe carries the whole line
                if (mem_valid_i) begin
                    state_d = WAIT_DEC;
                end
            end
            WAIT_DEC: begin
                if (dec_ready_i) begin
                    state_d = accept ? LOOKUP : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // A new flush arriving as the old one is taken stays pending
            flush_q <= flush_i || (flush_q && !flush_take);
        end
    end

    // Held request
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= fe_req_i;
        end
    end

endmodule

// ==== icache/ic_fetch_align.sv ====
// ############################
// Fetch group extraction
// Refill buffer and slot alignment
// ############################

`timescale 1ns/100ps

`include "ic_params.svh"

module ic_fetch_align
    import ic_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,

    input  logic                        out_valid_i,
    input  logic                        use_refill_i,
    input  fetch_req_t                  req_i,
    input  line_t                       store_line_i,

    input  logic                        mem_valid_i,
    input  line_t                       mem_data_i,

    output fetch_mask_t                 ic_valid_o,
    output inst_t [`IC_FETCH_WIDTH-1:0] ic_inst_o,
    output pc_t                         ic_pc_o,
    output fetch_mask_t                 ic_fetch_mask_o,
    output act_mask_t                   ic_act_mask_o,
    output wid_t                        ic_warp_id_o
);

    line_t refill_q;
    line_t src_line;

    // Copy of the last line returned by memory
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            refill_q <= '0;
        end else if (mem_valid_i) begin
            refill_q <= mem_data_i;
        end
    end

    assign src_line = use_refill_i ? refill_q : store_line_i;

    // Slot k takes word offset+k, cut off at the end of the line
    always_comb begin : extract
        offset_t off;
        off        = req_i.pc[$bits(offset_t)-1:0];
        ic_valid_o = '0;
        ic_inst_o  = '0;
        for (int k = 0; k < `IC_FETCH_WIDTH; k++) begin
            if (out_valid_i && req_i.fetch_mask[k]
                    && ((int'(off) + k) < `IC_LINE_INSTS)) begin
                ic_valid_o[k] = 1'b1;
                ic_inst_o[k]  = src_line[off + offset_t'(k)];
            end
        end
    end

    // Sideband only while a group is presented
    assign ic_pc_o         = out_valid_i ? req_i.pc : '0;
    assign ic_fetch_mask_o = out_valid_i ? req_i.fetch_mask : '0;
    assign ic_act_mask_o   = out_valid_i ? req_i.act_mask : '0;
    assign ic_warp_id_o    = out_valid_i ? req_i.warp_id : '0;

endmodule

// ==== icache/ic_store.sv ====
// ############################
// Tag and line arrays with valid bits
// Registered lookup result
// ############################

`timescale 1ns/100ps

`include "ic_params.svh"

module ic_store
    import ic_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,

    ic_store_if.store port,

    output line_t     line_o
);

    tag_t                     tag_q  [`IC_NUM_LINES];
    line_t                    line_q [`IC_NUM_LINES];
    logic [`IC_NUM_LINES-1:0] valid_q;

    logic                     hit_q;
    line_t                    rd_line_q;

    // ############################
    // Control state
    // ############################

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            if (port.clear) begin
                valid_q <= '0;
            end else if (port.fill) begin
                valid_q[port.fill_idx] <= 1'b1;
            end

            // Hold the result until the next lookup
            if (port.lookup) begin
                hit_q <= valid_q[port.lookup_idx]
                         && (tag_q[port.lookup_idx] == port.lookup_tag);
            end
        end
    end

    // ############################
    // Arrays
    // ############################

    always_ff @(posedge clk_i) begin
        if (port.fill) begin
            tag_q[port.fill_idx]  <= port.fill_tag;
            line_q[port.fill_idx] <= port.fill_data;
        end
        if (port.lookup) begin
            rd_line_q <= line_q[port.lookup_idx];
        end
    end

    assign port.hit = hit_q;
    assign line_o   = rd_line_q;

endmodule

// ==== common/ic_store_if.sv ====
// ############################
// Controller to tag/data store link
// ############################

`timescale 1ns/100ps

interface ic_store_if
    import ic_pkg::*;
();
    // Lookup of the accepted request
    logic   lookup;
    index_t lookup_idx;
    tag_t   lookup_tag;

    // Line fill from the memory response
    logic   fill;
    index_t fill_idx;
    tag_t   fill_tag;
    line_t  fill_data;

    // Invalidate all lines
    logic   clear;

    // Registered lookup result
    logic   hit;

    modport ctrl (
        output lookup, lookup_idx, lookup_tag,
        output fill, fill_idx, fill_tag, fill_data,
        output clear,
        input  hit
    );

    modport store (
        input  lookup, lookup_idx, lookup_tag,
        input  fill, fill_idx, fill_tag, fill_data,
        input  clear,
        output hit
    );

endinterface

// ==== common/ic_pkg.sv ====
// ############################
// Instruction cache types and controller states
// ############################

`include "ic_params.svh"

package ic_pkg;

    // ############################
    // Address fields
    // ############################

    // PC = {tag, index, offset}
    typedef logic [`IC_PC_WIDTH-1:0] pc_t;
    typedef logic [`IC_PC_WIDTH-`IC_LINE_IDX_BITS-1:0] line_addr_t;
    typedef logic [$clog2(`IC_NUM_LINES)-1:0] index_t;
    typedef logic [`IC_PC_WIDTH-`IC_LINE_IDX_BITS-$clog2(`IC_NUM_LINES)-1:0] tag_t;
    typedef logic [`IC_LINE_IDX_BITS-1:0] offset_t;

    // ############################
    // Payload
    // ############################

    typedef logic [`IC_INST_WIDTH-1:0] inst_t;
    typedef inst_t [`IC_LINE_INSTS-1:0] line_t;

    typedef logic [`IC_FETCH_WIDTH-1:0] fetch_mask_t;
    typedef logic [`IC_WARP_WIDTH-1:0] act_mask_t;
    typedef logic [$clog2(`IC_NUM_WARPS)-1:0] wid_t;

    // Request as handed over by the fetcher
    typedef struct packed {
        pc_t         pc;
        fetch_mask_t fetch_mask;
        act_mask_t   act_mask;
        wid_t        warp_id;
    } fetch_req_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        WAIT_MEM = 2'd2,
        WAIT_DEC = 2'd3
    } ic_state_e;

endpackage

// ==== common/ic_params.svh ====
// ############################
// Instruction cache geometry and field widths
// ############################

`ifndef IC_PARAMS_SVH
`define IC_PARAMS_SVH

// Program counter width
`define IC_PC_WIDTH 8
// Offset bits inside a cacheline
`define IC_LINE_IDX_BITS 2
`define IC_LINE_INSTS (1 << `IC_LINE_IDX_BITS)
// Number of cachelines
`define IC_NUM_LINES 8
// Encoded instruction width
`define IC_INST_WIDTH 4

// Fetch group size
// Must not exceed IC_LINE_INSTS, or the upper slots can never be valid
`define IC_FETCH_WIDTH 4

// Warp geometry
`define IC_NUM_WARPS 8
`define IC_WARP_WIDTH 32

`endif
